//--- build.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_exec_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/exec_alu.sv
src/exec_core.sv
tests/tb_exec_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f build.f --top-module tb_exec_core

./obj_dir/Vtb_exec_core | tee sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    exit 1
fi
exit 0

//--- tests/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

    // Local op codes for the shadow model
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_SLT  = 5;
    localparam int K_SLTU = 6;
    localparam int K_SLL  = 7;
    localparam int K_SRL  = 8;
    localparam int K_SRA  = 9;

    logic             clk;
    logic             arst_n;
    logic             instr_valid;
    logic [31:0]      instr;
    rv_exec_pkg::wb_s wb;

    // Stimulus table with one entry per strobe
    logic [31:0] q_instr[$];
    logic [31:0] q_res[$];                        // Expected result
    logic        q_tk[$];                         // Expected branch_taken
    logic        q_ill[$];                        // Expected illegal
    logic        q_we[$];                         // Expected reg_write
    logic        q_chk[$];                        // Result is defined
    int          q_rd[$];                         // Expected rd, -1 when unchecked
    int          q_grp[$];                        // Test group

    logic [31:0] sh [32];                         // Shadow registers
    string       names [1:7];
    integer      seed = 54557;
    int          errors = 0;
    int          grp_err = 0;
    int          cycles = 0;
    int          limit = 0;                       // 0 until the table is built

    exec_core dut (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                   // 20 ns period
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Shadow model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] alu_model(int k, logic [31:0] a, logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];                               // Shift amount from low bits
        case (k)
            K_ADD:   alu_model = a + b;
            K_SUB:   alu_model = a - b;
            K_AND:   alu_model = a & b;
            K_OR:    alu_model = a | b;
            K_XOR:   alu_model = a ^ b;
            K_SLT:   alu_model = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            K_SLTU:  alu_model = {31'd0, a < b};
            K_SLL:   alu_model = a << s;
            K_SRL:   alu_model = a >> s;
            K_SRA:   alu_model = a[31] ? ~(~a >> s) : (a >> s);  // Ones shifted in
            default: alu_model = 32'd0;
        endcase
    endfunction

    function automatic logic [2:0] f3_of(int k);
        case (k)
            K_ADD, K_SUB: f3_of = 3'b000;
            K_SLL:        f3_of = 3'b001;
            K_SLT:        f3_of = 3'b010;
            K_SLTU:       f3_of = 3'b011;
            K_XOR:        f3_of = 3'b100;
            K_SRL, K_SRA: f3_of = 3'b101;
            K_OR:         f3_of = 3'b110;
            default:      f3_of = 3'b111;         // AND
        endcase
    endfunction

    task automatic push_row(int grp, logic [31:0] w, logic [31:0] res,
                            logic tk, logic ill, logic we, logic chk, int rd);
        q_instr.push_back(w);
        q_res.push_back(res);
        q_tk.push_back(tk);
        q_ill.push_back(ill);
        q_we.push_back(we);
        q_chk.push_back(chk);
        q_rd.push_back(rd);
        q_grp.push_back(grp);
    endtask

    // Register-register form
    task automatic add_rr(int grp, int k, int rd, int rs1, int rs2);
        logic [31:0] w;
        logic [31:0] r;
        w = {(k == K_SUB || k == K_SRA) ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1),
             f3_of(k), 5'(rd), 7'b0110011};
        r = alu_model(k, sh[rs1], sh[rs2]);
        if (rd != 0) sh[rd] = r;
        push_row(grp, w, r, 1'b0, 1'b0, rd != 0, 1'b1, rd);
    endtask

    // Register-immediate form with shamt in imm[4:0]
    task automatic add_ri(int grp, int k, int rd, int rs1, logic [11:0] imm);
        logic [11:0] f;
        logic [31:0] b;
        logic [31:0] w;
        logic [31:0] r;
        if (k == K_SLL || k == K_SRL || k == K_SRA) begin
            f = {(k == K_SRA) ? 7'h20 : 7'h00, imm[4:0]};
            b = {27'd0, imm[4:0]};
        end else begin
            f = imm;
            b = {{20{imm[11]}}, imm};             // Sign extend
        end
        w = {f, 5'(rs1), f3_of(k), 5'(rd), 7'b0010011};
        r = alu_model(k, sh[rs1], b);
        if (rd != 0) sh[rd] = r;
        push_row(grp, w, r, 1'b0, 1'b0, rd != 0, 1'b1, rd);
    endtask

    // BEQ when beq is high else BNE with offset +8
    task automatic add_br(int grp, logic beq, int rs1, int rs2);
        logic [31:0] w;
        logic        tk;
        w  = {7'd0, 5'(rs2), 5'(rs1), beq ? 3'b000 : 3'b001, 5'b01000, 7'b1100011};
        tk = beq ? (sh[rs1] == sh[rs2]) : (sh[rs1] != sh[rs2]);
        push_row(grp, w, sh[rs1] - sh[rs2], tk, 1'b0, 1'b0, 1'b1, -1);
    endtask

    task automatic check_row(int i);
        if (!wb.valid) begin
            $display("[FAIL] row %0d o_wb.valid got %h exp 1", i, wb.valid);
            errors++;
            grp_err++;
        end else begin
            if (wb.illegal !== q_ill[i]) begin
                $display("[FAIL] row %0d o_wb.illegal got %h exp %h", i, wb.illegal, q_ill[i]);
                errors++;
                grp_err++;
            end
            if (q_chk[i] && wb.result !== q_res[i]) begin
                $display("[FAIL] row %0d o_wb.result got %h exp %h", i, wb.result, q_res[i]);
                errors++;
                grp_err++;
            end
            if (q_rd[i] >= 0 && wb.rd !== 5'(q_rd[i])) begin
                $display("[FAIL] row %0d o_wb.rd got %h exp %h", i, wb.rd, 5'(q_rd[i]));
                errors++;
                grp_err++;
            end
            if (wb.branch_taken !== q_tk[i]) begin
                $display("[FAIL] row %0d o_wb.branch_taken got %h exp %h",
                         i, wb.branch_taken, q_tk[i]);
                errors++;
                grp_err++;
            end
            if (wb.reg_write !== q_we[i]) begin
                $display("[FAIL] row %0d o_wb.reg_write got %h exp %h",
                         i, wb.reg_write, q_we[i]);
                errors++;
                grp_err++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Table build and run
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rv;
        int          n;
        int          k;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        names[1] = "reset and ADDI";
        names[2] = "dependent R-type";
        names[3] = "compare and shift";
        names[4] = "x0 writes";
        names[5] = "BEQ/BNE";
        names[6] = "illegal encodings";
        names[7] = "random mix";
        for (int r = 0; r < 32; r++) sh[r] = 32'd0;

        add_ri(1, K_ADD, 1, 0, 12'h123);
        add_ri(1, K_ADD, 2, 0, 12'hFFF);          // -1
        add_ri(1, K_ADD, 3, 0, 12'h800);          // Most negative imm
        add_ri(1, K_ADD, 4, 0, 12'h7FF);
        add_rr(2, K_ADD, 5, 1, 2);
        add_rr(2, K_SUB, 6, 5, 3);                // Uses x5 from the row before
        add_rr(2, K_AND, 7, 6, 4);
        add_rr(2, K_OR, 8, 7, 3);
        add_rr(2, K_XOR, 9, 8, 6);
        add_rr(2, K_ADD, 9, 9, 9);
        add_rr(3, K_SLT, 10, 2, 1);               // Opposite signs
        add_rr(3, K_SLTU, 11, 2, 1);
        add_ri(3, K_SLT, 12, 1, 12'hFFF);
        add_ri(3, K_SLTU, 13, 1, 12'hFFF);
        add_ri(3, K_SLL, 14, 3, 12'd4);
        add_rr(3, K_SRL, 15, 3, 1);
        add_rr(3, K_SRA, 16, 3, 1);               // Negative source
        add_ri(3, K_SRL, 17, 3, 12'd8);
        add_ri(3, K_SRA, 18, 3, 12'd8);
        add_rr(3, K_SLL, 19, 4, 1);
        add_ri(4, K_ADD, 0, 0, 12'h555);
        add_rr(4, K_ADD, 0, 1, 2);
        add_rr(4, K_OR, 20, 0, 0);                // Must read back zero
        add_br(5, 1'b1, 1, 1);
        add_br(5, 1'b1, 1, 2);
        add_br(5, 1'b0, 1, 2);
        add_br(5, 1'b0, 3, 3);
        add_br(5, 1'b1, 0, 0);
        push_row(6, {20'hABCDE, 5'd1, 7'b0110111}, 32'd0, 1'b0, 1'b1, 1'b0, 1'b0, -1);
        push_row(6, {7'h01, 5'd2, 5'd1, 3'b000, 5'd1, 7'b0110011},
                 32'd0, 1'b0, 1'b1, 1'b0, 1'b0, -1);  // funct7 not 0 or 0x20
        push_row(6, {7'h20, 5'd3, 5'd2, 3'b001, 5'd2, 7'b0010011},
                 32'd0, 1'b0, 1'b1, 1'b0, 1'b0, -1);  // No SLAI
        add_ri(6, K_ADD, 22, 1, 12'd0);           // Read back x1
        add_ri(6, K_ADD, 23, 2, 12'd0);
        for (int j = 0; j < 20; j++) begin
            rv = $random(seed);
            k  = int'(rv[7:0]) % 10;
            if (k == K_SUB || rv[20])
                add_rr(7, k, int'(rv[11:8]), int'(rv[15:12]), int'(rv[19:16]));
            else
                add_ri(7, k, int'(rv[11:8]), int'(rv[15:12]), rv[31:20]);
        end

        n     = q_instr.size();
        limit = 2 * n + 50;
        repeat (8) @(posedge clk);
        #2 arst_n = 1'b1;
        @(posedge clk);
        #1;
        if (wb.valid !== 1'b0) begin
            $display("[FAIL] o_wb.valid after reset got %h exp 0", wb.valid);
            errors++;
            grp_err++;
        end
        #1;
        instr_valid = 1'b1;
        instr       = q_instr[0];
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            check_row(i);
            if (i == n - 1 || q_grp[i + 1] != q_grp[i]) begin
                $display("test %0d %s: %s (%0d errors)", q_grp[i], names[q_grp[i]],
                         (grp_err == 0) ? "ok" : "FAILED", grp_err);
                grp_err = 0;
            end
            #1;
            if (i + 1 < n) instr = q_instr[i + 1];
            else instr_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        if (wb.valid !== 1'b0) begin
            $display("[FAIL] o_wb.valid after the last strobe got %h exp 0", wb.valid);
            errors++;
        end
        $display("Summary: %0d rows, %0d errors, %0d cycles", n, errors, cycles);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- src/exec_core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module exec_core (
    input  logic             i_clk,          // Core clock
    input  logic             i_arst_n,       // Async reset, active low
    input  logic             i_instr_valid,  // One strobe per instruction
    input  logic [31:0]      i_instr,        // Instruction word
    output rv_exec_pkg::wb_s o_wb            // Writeback report, 1 cycle later
);

    // ---------------------------------------------------------------------------
    // Interconnect
    // ---------------------------------------------------------------------------
    rv_exec_pkg::decoded_s dec;              // Decoder to execute
    logic [`RV_XLEN-1:0]   rs1_data;         // Operand A
    logic [`RV_XLEN-1:0]   rs2_data;         // Operand B
    logic                  we;               // Writeback enable
    logic [`RV_REG_AW-1:0] rd;               // Writeback index
    logic [`RV_XLEN-1:0]   rd_data;          // Writeback data

    // Producer
    instr_decoder u_decoder (
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_dec         (dec)
    );

    // Buffer, read addresses straight from the decoded fields
    reg_file u_regs (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1      (dec.rs1),
        .i_rs2      (dec.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (we),
        .i_rd       (rd),
        .i_rd_data  (rd_data)
    );

    // Consumer
    exec_alu u_exec (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_dec      (dec),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_we       (we),
        .o_rd       (rd),
        .o_rd_data  (rd_data),
        .o_wb       (o_wb)
    );

endmodule

//--- src/exec_alu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module exec_alu (
    input  logic                  i_clk,       // Core clock
    input  logic                  i_arst_n,    // Async reset, active low
    input  rv_exec_pkg::decoded_s i_dec,       // From decoder
    input  logic [`RV_XLEN-1:0]   i_rs1_data,  // Operand A source
    input  logic [`RV_XLEN-1:0]   i_rs2_data,  // Operand B source
    output logic                  o_we,        // Register write enable
    output logic [`RV_REG_AW-1:0] o_rd,        // Register write index
    output logic [`RV_XLEN-1:0]   o_rd_data,   // Register write data
    output rv_exec_pkg::wb_s      o_wb         // Registered report
);

    logic [`RV_XLEN-1:0] op_a;                 // ALU input A
    logic [`RV_XLEN-1:0] op_b;                 // ALU input B
    logic [`RV_XLEN-1:0] result;               // ALU output
    logic                zero;                 // Result is zero
    logic                accept;               // Valid and legal
    logic                taken;                // Branch outcome

    assign op_a = i_rs1_data;
    assign op_b = i_dec.use_imm ? i_dec.imm : i_rs2_data;  // Imm or rs2

    // ---------------------------------------------------------------------------
    // ALU
    // ---------------------------------------------------------------------------
    always_comb begin
        case (i_dec.alu_op)
            rv_exec_pkg::ALU_ADD:  result = op_a + op_b;
            rv_exec_pkg::ALU_SUB:  result = op_a - op_b;
            rv_exec_pkg::ALU_AND:  result = op_a & op_b;
            rv_exec_pkg::ALU_OR:   result = op_a | op_b;
            rv_exec_pkg::ALU_XOR:  result = op_a ^ op_b;
            rv_exec_pkg::ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_exec_pkg::ALU_SLTU: result = {31'd0, op_a < op_b};
            rv_exec_pkg::ALU_SLL:  result = op_a << op_b[4:0];        // Low 5 bits only
            rv_exec_pkg::ALU_SRL:  result = op_a >> op_b[4:0];
            rv_exec_pkg::ALU_SRA:  result = $signed(op_a) >>> op_b[4:0];  // Sign fill
            default:               result = '0;   // Unused codes
        endcase
    end

    assign zero = (result == '0);

    // ---------------------------------------------------------------------------
    // Branch resolve and write gating
    // ---------------------------------------------------------------------------
    assign accept    = i_dec.valid && !i_dec.illegal;
    assign taken     = accept && i_dec.is_branch && (zero == i_dec.branch_on_zero);
    assign o_we      = accept && i_dec.reg_write && (i_dec.rd != '0);  // x0 never
    assign o_rd      = i_dec.rd;
    assign o_rd_data = result;

    // Report lands one edge after the strobe, with the register update
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb <= '0;
        end else begin
            o_wb.valid        <= i_dec.valid;
            o_wb.illegal      <= i_dec.valid && i_dec.illegal;
            o_wb.rd           <= i_dec.rd;
            o_wb.result       <= result;
            o_wb.reg_write    <= o_we;              // What actually happened
            o_wb.branch_taken <= taken;
        end
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module reg_file (
    input  logic                  i_clk,       // Core clock
    input  logic                  i_arst_n,    // Active-low async reset
    input  logic [`RV_REG_AW-1:0] i_rs1,       // Read port A index
    input  logic [`RV_REG_AW-1:0] i_rs2,       // Read port B index
    output logic [`RV_XLEN-1:0]   o_rs1_data,  // Read port A data
    output logic [`RV_XLEN-1:0]   o_rs2_data,  // Read port B data
    input  logic                  i_we,        // Write enable
    input  logic [`RV_REG_AW-1:0] i_rd,        // Write index
    input  logic [`RV_XLEN-1:0]   i_rd_data    // Write data
);

    // ---------------------------------------------------------------------------
    // Storage
    // ---------------------------------------------------------------------------
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];     // Entry 0 never written

    // Whole array clears on reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_rd_data;           // Lands at the edge
        end
    end

    // ---------------------------------------------------------------------------
    // Read ports
    // ---------------------------------------------------------------------------
    // Same-cycle write not forwarded so the old value is seen
    always_comb begin
        if (i_rs1 == '0)
            o_rs1_data = '0;                   // x0 hard-wired
        else
            o_rs1_data = regs[i_rs1];

        if (i_rs2 == '0)
            o_rs2_data = '0;
        else
            o_rs2_data = regs[i_rs2];
    end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module instr_decoder (
    input  logic                  i_instr_valid,  // One-cycle strobe
    input  logic [31:0]           i_instr,        // Instruction word
    output rv_exec_pkg::decoded_s o_dec           // Decoded fields, same cycle
);

    // ---------------------------------------------------------------------------
    // Field split
    // ---------------------------------------------------------------------------
    rv_isa_pkg::opcode_e     opc;                  // Major opcode
    rv_isa_pkg::funct3_alu_e f3_alu;               // funct3 as ALU code
    rv_isa_pkg::funct3_br_e  f3_br;                // funct3 as branch code
    logic [6:0]              funct7;               // Upper bits
    logic [`RV_XLEN-1:0]     imm_i;                // I-type
    logic [`RV_XLEN-1:0]     imm_sh;               // Shift amount
    logic [`RV_XLEN-1:0]     imm_b;                // B-type
    rv_exec_pkg::alu_op_e    f3_op;                // funct3 mapped to ALU op
    logic                    is_op;                // Register-register form
    logic                    is_shift;             // Any shift funct3

    assign opc    = rv_isa_pkg::opcode_e'(i_instr[6:0]);
    assign f3_alu = rv_isa_pkg::funct3_alu_e'(i_instr[14:12]);
    assign f3_br  = rv_isa_pkg::funct3_br_e'(i_instr[14:12]);
    assign funct7 = i_instr[31:25];
    assign is_op  = (opc == rv_isa_pkg::OPC_OP);

    assign imm_i  = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_sh = {27'd0, i_instr[24:20]};         // shamt, never sign-extended
    assign imm_b  = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                     i_instr[30:25], i_instr[11:8], 1'b0};

    assign is_shift = (f3_alu == rv_isa_pkg::F3_SLL) ||
                      (f3_alu == rv_isa_pkg::F3_SRL_SRA);

    // funct3 to ALU op, shared by OP and OP-IMM
    always_comb begin
        case (f3_alu)
            rv_isa_pkg::F3_ADD_SUB: f3_op = (is_op && funct7[5]) ? rv_exec_pkg::ALU_SUB
                                                                : rv_exec_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     f3_op = rv_exec_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     f3_op = rv_exec_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    f3_op = rv_exec_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     f3_op = rv_exec_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: f3_op = funct7[5] ? rv_exec_pkg::ALU_SRA
                                                      : rv_exec_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      f3_op = rv_exec_pkg::ALU_OR;
            default:                f3_op = rv_exec_pkg::ALU_AND;  // F3_AND
        endcase
    end

    // ---------------------------------------------------------------------------
    // Control decode
    // ---------------------------------------------------------------------------
    always_comb begin
        o_dec        = '0;
        o_dec.valid  = i_instr_valid;
        o_dec.rs1    = i_instr[19:15];
        o_dec.rs2    = i_instr[24:20];
        o_dec.alu_op = f3_op;
        case (opc)
            rv_isa_pkg::OPC_OP: begin
                o_dec.rd        = i_instr[11:7];
                o_dec.reg_write = 1'b1;
                // Alt form only on ADD/SUB and SRL/SRA
                if (funct7 == rv_isa_pkg::F7_ALT)
                    o_dec.illegal = !(f3_alu == rv_isa_pkg::F3_ADD_SUB ||
                                      f3_alu == rv_isa_pkg::F3_SRL_SRA);
                else
                    o_dec.illegal = (funct7 != rv_isa_pkg::F7_BASE);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                o_dec.rd        = i_instr[11:7];
                o_dec.reg_write = 1'b1;
                o_dec.use_imm   = 1'b1;
                o_dec.imm       = is_shift ? imm_sh : imm_i;
                if (f3_alu == rv_isa_pkg::F3_SLL)
                    o_dec.illegal = (funct7 != rv_isa_pkg::F7_BASE);  // No SLAI
                else if (f3_alu == rv_isa_pkg::F3_SRL_SRA)
                    o_dec.illegal = (funct7 != rv_isa_pkg::F7_BASE) &&
                                    (funct7 != rv_isa_pkg::F7_ALT);
            end
            rv_isa_pkg::OPC_BRANCH: begin
                o_dec.alu_op    = rv_exec_pkg::ALU_SUB;       // Compare by subtract
                o_dec.imm       = imm_b;                      // Target math lives elsewhere
                o_dec.is_branch = (f3_br == rv_isa_pkg::F3_BEQ) ||
                                  (f3_br == rv_isa_pkg::F3_BNE);
                o_dec.branch_on_zero = (f3_br == rv_isa_pkg::F3_BEQ);
                o_dec.illegal   = !o_dec.is_branch;           // BLT and friends
            end
            default: o_dec.illegal = 1'b1;                    // Unknown opcode
        endcase
    end

endmodule

//--- src/rv_exec_pkg.sv
`include "rv_defs.svh"

package rv_exec_pkg;

    // -----------------------------------------------------------------------
    // ALU operation select
    // -----------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,           // a + b
        ALU_SUB  = 4'd1,           // a - b and branch compare
        ALU_AND  = 4'd2,           // a & b
        ALU_OR   = 4'd3,           // a | b
        ALU_XOR  = 4'd4,           // a ^ b
        ALU_SLT  = 4'd5,           // Signed less than
        ALU_SLTU = 4'd6,           // Unsigned less than
        ALU_SLL  = 4'd7,           // Logical left
        ALU_SRL  = 4'd8,           // Logical right
        ALU_SRA  = 4'd9            // Arithmetic right
    } alu_op_e;

    // -----------------------------------------------------------------------
    // Decoder to execute
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic                  valid;          // Strobe passed through
        logic                  illegal;        // Unhandled encoding
        alu_op_e               alu_op;         // ALU function
        logic [`RV_REG_AW-1:0] rs1;            // Source A index
        logic [`RV_REG_AW-1:0] rs2;            // Source B index
        logic [`RV_REG_AW-1:0] rd;             // Destination index
        logic                  use_imm;        // B from imm instead of rs2
        logic [`RV_XLEN-1:0]   imm;            // Sign-extended immediate
        logic                  reg_write;      // Writes rd
        logic                  is_branch;      // BEQ or BNE
        logic                  branch_on_zero; // High for BEQ
    } decoded_s;

    // -----------------------------------------------------------------------
    // Registered writeback report
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic                  valid;          // One cycle per instruction
        logic                  illegal;        // Rejected without state change
        logic [`RV_REG_AW-1:0] rd;             // Destination index
        logic [`RV_XLEN-1:0]   result;         // ALU result
        logic                  reg_write;      // Register actually written
        logic                  branch_taken;   // Branch outcome
    } wb_s;

endpackage

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // -----------------------------------------------------------------------
    // Major opcodes, instr[6:0]
    // -----------------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP      = 7'b0110011,  // Register-register ALU
        OPC_OP_IMM  = 7'b0010011,  // Register-immediate ALU
        OPC_BRANCH  = 7'b1100011   // Conditional branch
    } opcode_e;

    // -----------------------------------------------------------------------
    // funct3 for OP and OP-IMM
    // -----------------------------------------------------------------------
    typedef enum logic [2:0] {
        F3_ADD_SUB  = 3'b000,      // ADD/SUB, ADDI
        F3_SLL      = 3'b001,      // SLL, SLLI
        F3_SLT      = 3'b010,      // SLT, SLTI
        F3_SLTU     = 3'b011,      // SLTU, SLTIU
        F3_XOR      = 3'b100,      // XOR, XORI
        F3_SRL_SRA  = 3'b101,      // SRL/SRA and immediate forms
        F3_OR       = 3'b110,      // OR, ORI
        F3_AND      = 3'b111       // AND, ANDI
    } funct3_alu_e;

    // -----------------------------------------------------------------------
    // funct3 for BRANCH
    // -----------------------------------------------------------------------
    // Only the two zero-flag branches exist here
    typedef enum logic [2:0] {
        F3_BEQ      = 3'b000,      // Taken when equal
        F3_BNE      = 3'b001       // Taken when not equal
    } funct3_br_e;

    // funct7 bit 5 picks SUB over ADD and SRA over SRL
    localparam logic [6:0] F7_BASE = 7'b0000000;  // Normal form
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB / SRA form

endpackage

//--- src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ---------------------------------------------------------------------------
// Execute slice sizing
// ---------------------------------------------------------------------------

// Datapath width, RV32I only
`define RV_XLEN     32

// Architectural integer registers
`define RV_NREGS    32

// Register index width, log2 of RV_NREGS
`define RV_REG_AW   5

// ---------------------------------------------------------------------------
// These three move together if the core ever changes size
// ---------------------------------------------------------------------------

`endif
